//--- fetch.f
source/fetch_pkg.sv
source/sync_fifo.sv
source/trap_csr_regs.sv
source/wb_prefetch.sv
source/fetch_top.sv
dv/wb_mem_model.sv
dv/tb_fetch_top.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= fetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_fetch_top.sv
/* testbench for the fetch front end, expects memory data to be word address xor 32'h1357_9bdf.
   runs boot, a long consumer stall and a table of CSR writes and redirects */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int unsigned WAIT_LIMIT = 2000;
    localparam int unsigned N_ROWS     = 8;

    typedef struct packed {
        logic                   csr_we;
        csr_sel_t               csr_sel;
        word_t                  csr_wdata;
        word_t                  exp_rdata;
        pc_sel_t                pc_sel;
        word_t                  jump_target;
        logic [TRAP_CODE_W-1:0] cause;
        word_t                  exp_target;
        logic [7:0]             n_words;
    } case_row_t;

    // we, sel, wdata, read-back, redirect, jump, cause, target, words to consume
    case_row_t rows [N_ROWS] = '{
        '{1'b0, CSR_MTVEC, 32'h0, 32'h0, PC_JUMP, 32'h8000_0100, 5'd0, 32'h8000_0100, 8'd6},
        '{1'b1, CSR_MTVEC, 32'h1000, 32'h1000, PC_TRAP, 32'h0, 5'd3, 32'h1000, 8'd5},
        '{1'b1, CSR_MTVEC, 32'h2001, 32'h2001, PC_TRAP, 32'h0, 5'd5, 32'h2014, 8'd5},
        '{1'b1, CSR_MTVEC, 32'h3002, 32'h3000, PC_TRAP, 32'h0, 5'd7, 32'h3000, 8'd5},
        '{1'b1, CSR_MEPC, 32'h8000_0237, 32'h8000_0234, PC_MEPC, 32'h0, 5'd0,
          32'h8000_0234, 8'd6},
        '{1'b1, CSR_MTVEC, 32'h4003, 32'h4000, PC_TRAP, 32'h0, 5'd2, 32'h4000, 8'd4},
        '{1'b1, CSR_MTVEC, 32'h5001, 32'h5001, PC_TRAP, 32'h0, 5'd31, 32'h507c, 8'd5},
        '{1'b0, CSR_MTVEC, 32'h0, 32'h0, PC_JUMP, 32'h8000_0040, 5'd0, 32'h8000_0040, 8'd10}
    };

    logic                   clk;
    logic                   rstn;
    logic                   valid;
    word_t                  instr;
    word_t                  pc;
    logic                   stall;
    logic                   new_pc_en;
    pc_sel_t                pc_sel;
    word_t                  branch_target;
    logic [TRAP_CODE_W-1:0] mcause_code;
    logic                   csr_we;
    csr_sel_t               csr_sel;
    word_t                  csr_wdata;
    word_t                  csr_rdata;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic [XLEN-3:0]        wb_adr;
    logic                   wb_stall;
    logic                   wb_ack;
    word_t                  wb_dat;

    integer      seed = 32'hb257;
    string       test_name;
    int unsigned value_errors;
    int unsigned timeout_errors;
    int unsigned consumed_cnt;
    int unsigned accepted_cnt;
    word_t       exp_pc;
    logic        hold_stall;
    logic        bound_check;

    fetch_top dut_i
    (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .valid_o         (valid),
        .instr_o         (instr),
        .pc_o            (pc),
        .stall_i         (stall),
        .new_pc_en_i     (new_pc_en),
        .pc_sel_i        (pc_sel),
        .branch_target_i (branch_target),
        .mcause_code_i   (mcause_code),
        .csr_we_i        (csr_we),
        .csr_sel_i       (csr_sel),
        .csr_wdata_i     (csr_wdata),
        .csr_rdata_o     (csr_rdata),
        .wb_cyc_o        (wb_cyc),
        .wb_stb_o        (wb_stb),
        .wb_adr_o        (wb_adr),
        .wb_stall_i      (wb_stall),
        .wb_ack_i        (wb_ack),
        .wb_dat_i        (wb_dat)
    );

    wb_mem_model wb_mem_model_i
    (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_adr_i   (wb_adr),
        .wb_stall_o (wb_stall),
        .wb_ack_o   (wb_ack),
        .wb_dat_o   (wb_dat)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // instruction the memory holds at a byte address
    function automatic word_t expected_instr(input word_t addr);
        return {2'b00, addr[XLEN-1:2]} ^ 32'h1357_9bdf;
    endfunction

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_pc(input string what, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: %s pc expected %h actual %h", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic wait_consumed(input int unsigned n_words);
        int unsigned goal;
        int unsigned cycles;
        goal   = consumed_cnt + n_words;
        cycles = 0;
        while (consumed_cnt < goal && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (consumed_cnt < goal)
        begin
            timeout_errors++;
            $display("%s: the core got only %0d of %0d words within %0d cycles", test_name,
                     n_words - (goal - consumed_cnt), n_words, WAIT_LIMIT);
        end
    endtask

    // consumer stall is random unless held
    always @(posedge clk)
    begin
        #5;
        if (hold_stall)
            stall = 1'b1;
        else
            stall = (($random(seed) & 3) == 0);
    end

    // everything is stable at the falling edge
    always @(negedge clk)
    begin
        if (rstn)
        begin
            if (wb_cyc && wb_stb && !wb_stall)
                accepted_cnt++;
            if (valid && !stall)
            begin
                check_pc("consumed", exp_pc, pc);
                check_word("consumed instr", expected_instr(exp_pc), instr);
                exp_pc = exp_pc + 32'd4;
                consumed_cnt++;
            end
            // without redirects every request still owns a buffer slot
            if (bound_check && (accepted_cnt - consumed_cnt > 8))
            begin
                value_errors++;
                $display("** Error %s: in-flight words expected <= 8 actual %0d", test_name,
                         accepted_cnt - consumed_cnt);
            end
        end
    end

    initial
    begin
        case_row_t row;
        rstn           = 1'b0;
        stall          = 1'b0;
        new_pc_en      = 1'b0;
        pc_sel         = PC_JUMP;
        branch_target  = '0;
        mcause_code    = '0;
        csr_we         = 1'b0;
        csr_sel        = CSR_MTVEC;
        csr_wdata      = '0;
        value_errors   = 0;
        timeout_errors = 0;
        consumed_cnt   = 0;
        accepted_cnt   = 0;
        exp_pc         = BOOT_PC;
        hold_stall     = 1'b0;
        bound_check    = 1'b0;
        test_name      = "reset";

        repeat (16)
        begin
            @(posedge clk);
            #5;
            check_flag("valid in reset", 1'b0, valid);
            check_flag("cyc in reset", 1'b0, wb_cyc);
            check_flag("stb in reset", 1'b0, wb_stb);
        end
        rstn = 1'b1;

        // nothing is requested in the BOOT cycle
        test_name = "boot";
        check_flag("valid in boot", 1'b0, valid);
        check_flag("cyc in boot", 1'b0, wb_cyc);
        check_flag("stb in boot", 1'b0, wb_stb);
        @(posedge clk);
        #5;
        check_flag("cyc after boot", 1'b1, wb_cyc);
        check_flag("stb after boot", 1'b1, wb_stb);
        check_word("first address", BOOT_PC, {wb_adr, 2'b00});
        bound_check = 1'b1;
        wait_consumed(12);

        // a long stall fills the buffer and requests must stop
        test_name = "stall";
        @(posedge clk);
        hold_stall = 1'b1;
        repeat (40) @(posedge clk);
        hold_stall = 1'b0;
        #5;
        check_flag("valid with full buffer", 1'b1, valid);
        check_flag("cyc with full buffer", 1'b0, wb_cyc);
        check_flag("stb with full buffer", 1'b0, wb_stb);
        wait_consumed(12);
        bound_check = 1'b0;

        for (int i = 0; i < N_ROWS; i++)
        begin
            row       = rows[i];
            test_name = $sformatf("row %0d", i);
            if (row.csr_we)
            begin
                @(posedge clk);
                #5;
                csr_we    = 1'b1;
                csr_sel   = row.csr_sel;
                csr_wdata = row.csr_wdata;
                @(posedge clk);
                #5;
                csr_we = 1'b0;
                check_word("csr read-back", row.exp_rdata, csr_rdata);
            end
            @(posedge clk);
            #5;
            new_pc_en     = 1'b1;
            pc_sel        = row.pc_sel;
            branch_target = row.jump_target;
            mcause_code   = row.cause;
            @(posedge clk);
            #5;
            new_pc_en = 1'b0;
            // the stream restarts at the target since a word taken in the redirect cycle was old
            exp_pc = row.exp_target;
            check_pc("after redirect", row.exp_target, pc);
            check_flag("valid after redirect", 1'b0, valid);
            wait_consumed(row.n_words);
            if (timeout_errors != 0)
                break;
        end

        $display("errors: %0d value, %0d timeout, %0d words consumed", value_errors,
                 timeout_errors, consumed_cnt);
        if (value_errors == 0 && timeout_errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/wb_mem_model.sv
/* pipelined Wishbone read slave, data is the word address xor a fixed key.
   stalls at random and acks in order one to four cycles after a request is taken */
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    input  wire logic                      wb_cyc_i,
    input  wire logic                      wb_stb_i,
    input  wire logic [fetch_pkg::XLEN-3:0] wb_adr_i,
    output logic                           wb_stall_o,
    output logic                           wb_ack_o,
    output fetch_pkg::word_t               wb_dat_o
);

    import fetch_pkg::*;

    localparam word_t DATA_KEY = 32'h1357_9bdf;

    integer seed = 32'hb257;

    // taken requests, oldest first, with the cycle their ack becomes due
    logic [XLEN-3:0] adr_q [$];
    int unsigned     due_q [$];
    int unsigned     cycle_cnt;
    logic            take_req;
    logic            ack_now;
    logic [XLEN-3:0] ack_adr;

    initial
    begin
        wb_stall_o = 1'b0;
        wb_ack_o   = 1'b0;
        wb_dat_o   = '0;
        cycle_cnt  = 0;
    end

    always @(posedge clk_i)
    begin
        // decide on the values the master saw during the cycle that just ended
        take_req = rstn_i && wb_cyc_i && wb_stb_i && !wb_stall_o;
        ack_now  = rstn_i && (due_q.size() != 0) && (due_q[0] <= cycle_cnt);
        ack_adr  = '0;
        if (ack_now)
        begin
            ack_adr = adr_q.pop_front();
            void'(due_q.pop_front());
        end
        if (take_req)
        begin
            adr_q.push_back(wb_adr_i);
            due_q.push_back(cycle_cnt + 1 + ($random(seed) & 3));
        end
        if (!rstn_i)
        begin
            adr_q.delete();
            due_q.delete();
        end
        #5;
        wb_ack_o   = ack_now;
        wb_dat_o   = ack_now ? ({2'b00, ack_adr} ^ DATA_KEY) : '0;
        // roughly one cycle in four stalls
        wb_stall_o = rstn_i && (($random(seed) & 3) == 0);
        cycle_cnt  = cycle_cnt + 1;
    end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
/* instruction fetch front end, read-only pipelined Wishbone master with trap CSRs.
   the slave must ack every accepted request exactly once and in order */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
(
    input  wire logic                                 clk_i,
    input  wire logic                                 rstn_i,

    // core side
    output logic                                      valid_o,
    output fetch_pkg::word_t                          instr_o,
    output fetch_pkg::word_t                          pc_o,
    input  wire logic                                 stall_i,
    input  wire logic                                 new_pc_en_i,
    input  wire fetch_pkg::pc_sel_t                   pc_sel_i,
    input  wire fetch_pkg::word_t                     branch_target_i,
    input  wire logic [fetch_pkg::TRAP_CODE_W-1:0]    mcause_code_i,

    // CSR write strobe and read-back
    input  wire logic                                 csr_we_i,
    input  wire fetch_pkg::csr_sel_t                  csr_sel_i,
    input  wire fetch_pkg::word_t                     csr_wdata_i,
    output fetch_pkg::word_t                          csr_rdata_o,

    // Wishbone bus
    output logic                                      wb_cyc_o,
    output logic                                      wb_stb_o,
    output logic [fetch_pkg::XLEN-3:0]                wb_adr_o,
    input  wire logic                                 wb_stall_i,
    input  wire logic                                 wb_ack_i,
    input  wire fetch_pkg::word_t                     wb_dat_i
);

    import fetch_pkg::*;

    // CSR values steering the redirect targets
    mtvec_u mtvec;
    word_t  mepc;

    wb_prefetch wb_prefetch_i
    (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wb_cyc_o        (wb_cyc_o),
        .wb_stb_o        (wb_stb_o),
        .wb_adr_o        (wb_adr_o),
        .wb_stall_i      (wb_stall_i),
        .wb_ack_i        (wb_ack_i),
        .wb_dat_i        (wb_dat_i),
        .valid_o         (valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .stall_i         (stall_i),
        .new_pc_en_i     (new_pc_en_i),
        .pc_sel_i        (pc_sel_i),
        .branch_target_i (branch_target_i),
        .mcause_code_i   (mcause_code_i),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc)
    );

    trap_csr_regs trap_csr_regs_i
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .csr_we_i    (csr_we_i),
        .csr_sel_i   (csr_sel_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .mtvec_o     (mtvec),
        .mepc_o      (mepc)
    );

endmodule

`default_nettype wire

//--- source/wb_prefetch.sv
/* pipelined Wishbone read master, acks must come back in order, err and retry are not handled.
   a redirect clears the buffer and the acks of requests issued before it are dropped */
`timescale 1ns/1ps
`default_nettype none

module wb_prefetch
(
    input  wire logic                                 clk_i,
    input  wire logic                                 rstn_i,

    // Wishbone master, word addressed
    output logic                                      wb_cyc_o,
    output logic                                      wb_stb_o,
    output logic [fetch_pkg::XLEN-3:0]                wb_adr_o,
    input  wire logic                                 wb_stall_i,
    input  wire logic                                 wb_ack_i,
    input  wire fetch_pkg::word_t                     wb_dat_i,

    // core side
    output logic                                      valid_o,
    output fetch_pkg::word_t                          instr_o,
    output fetch_pkg::word_t                          pc_o,
    input  wire logic                                 stall_i,
    input  wire logic                                 new_pc_en_i,
    input  wire fetch_pkg::pc_sel_t                   pc_sel_i,
    input  wire fetch_pkg::word_t                     branch_target_i,
    input  wire logic [fetch_pkg::TRAP_CODE_W-1:0]    mcause_code_i,

    // trap CSRs
    input  wire fetch_pkg::mtvec_u                    mtvec_i,
    input  wire fetch_pkg::word_t                     mepc_i
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {BOOT, REQUESTING, BUFFER_FULL} fetch_state_t;

    fetch_state_t state_q, state_d;

    word_t fetch_pc_q, fetch_pc_d;
    word_t core_pc_q, core_pc_d;
    word_t trap_target;
    word_t new_pc;

    // instruction buffer
    logic                   ff_wr, ff_rd;
    logic                   ff_full, ff_empty;
    logic [BUF_DEPTH_POT:0] ff_fill_count;
    word_t                  ff_rdata;

    // useful requests still waiting for their ack
    logic [BUF_DEPTH_POT:0] req_pend_q, req_pend_d;

    // acks of requests made stale by a redirect, wider since redirects can pile up
    logic [BUF_DEPTH_POT+3:0] ack_ignore_q, ack_ignore_d;

    // words in flight or buffered, bounded by the buffer depth
    logic [BUF_DEPTH_POT+1:0] occupancy;
    logic                     one_till_full;

    logic wb_req_ok;
    logic kept_ack;

    sync_fifo
    #(
        .BW          (XLEN),
        .FF_SIZE_POT (BUF_DEPTH_POT)
    )
    sync_fifo_i
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .clear_i      (new_pc_en_i),
        .wr_i         (ff_wr),
        .data_i       (wb_dat_i),
        .rd_i         (ff_rd),
        .data_o       (ff_rdata),
        .full_o       (ff_full),
        .empty_o      (ff_empty),
        .fill_count_o (ff_fill_count)
    );

    // trap vector, reserved modes never get stored so default acts as direct
    always_comb
    begin
        case (mtvec_i.fields.mode)
            MTVEC_VECTORED:
                trap_target = {mtvec_i.fields.base + (XLEN-2)'(mcause_code_i), 2'b00};
            default:
                trap_target = {mtvec_i.fields.base, 2'b00};
        endcase
    end

    always_comb
    begin
        case (pc_sel_i)
            PC_MEPC: new_pc = mepc_i;
            PC_TRAP: new_pc = trap_target;
            default: new_pc = branch_target_i;
        endcase
    end

    // bus requests only while in REQUESTING
    assign wb_cyc_o  = (state_q == REQUESTING);
    assign wb_stb_o  = (state_q == REQUESTING);
    assign wb_adr_o  = fetch_pc_q[XLEN-1:2];
    assign wb_req_ok = wb_cyc_o && wb_stb_o && !wb_stall_i;

    assign occupancy     = {1'b0, req_pend_q} + {1'b0, ff_fill_count};
    assign one_till_full = (occupancy == (BUF_DEPTH_POT+2)'((1 << BUF_DEPTH_POT) - 1));

    always_comb
    begin
        state_d    = state_q;
        fetch_pc_d = fetch_pc_q;

        case (state_q)
            BOOT:
            begin
                // one idle cycle, fetch_pc_q already holds BOOT_PC
                state_d = REQUESTING;
            end
            REQUESTING:
            begin
                // a stalled request keeps its address
                if (wb_req_ok)
                    fetch_pc_d = fetch_pc_q + 32'd4;
                // stop once every buffer slot is spoken for
                if (one_till_full && wb_req_ok && !new_pc_en_i && !ff_rd)
                    state_d = BUFFER_FULL;
            end
            BUFFER_FULL:
            begin
                // a consumed word or a cleared buffer frees a slot
                if (ff_rd || new_pc_en_i)
                    state_d = REQUESTING;
            end
            default:
                state_d = BOOT;
        endcase

        if (new_pc_en_i)
            fetch_pc_d = new_pc;
    end

    // an ack is kept when no stale ack is still due
    assign kept_ack = wb_ack_i && (ack_ignore_q == '0);

    // the word of an ack in the redirect cycle belongs to the old stream
    assign ff_wr = kept_ack && !new_pc_en_i;

    always_comb
    begin
        ack_ignore_d = ack_ignore_q;
        req_pend_d   = req_pend_q;

        if (wb_ack_i)
        begin
            if (ack_ignore_q != '0)
                ack_ignore_d = ack_ignore_q - 1'b1;
            else
                req_pend_d = req_pend_q - 1'b1;
        end

        if (wb_req_ok)
            req_pend_d = req_pend_d + 1'b1;

        // everything still in flight turns stale, including this cycle's request
        if (new_pc_en_i)
        begin
            ack_ignore_d = ack_ignore_d + (BUF_DEPTH_POT+4)'(req_pend_d);
            req_pend_d   = '0;
        end
    end

    // core consumes the head word whenever it is not stalled
    assign ff_rd = !ff_empty && !stall_i;

    always_comb
    begin
        core_pc_d = core_pc_q;
        if (ff_rd)
            core_pc_d = core_pc_q + 32'd4;
        if (new_pc_en_i)
            core_pc_d = new_pc;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            state_q      <= BOOT;
            fetch_pc_q   <= BOOT_PC;
            core_pc_q    <= BOOT_PC;
            req_pend_q   <= '0;
            ack_ignore_q <= '0;
        end
        else
        begin
            state_q      <= state_d;
            fetch_pc_q   <= fetch_pc_d;
            core_pc_q    <= core_pc_d;
            req_pend_q   <= req_pend_d;
            ack_ignore_q <= ack_ignore_d;
        end
    end

    assign valid_o = !ff_empty;
    assign instr_o = ff_rdata;
    assign pc_o    = core_pc_q;

    // back-pressure keeps in-flight plus buffered words within the buffer
    a_occupancy_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        occupancy <= (BUF_DEPTH_POT+2)'(1 << BUF_DEPTH_POT));

    // a slot was reserved when the request went out
    a_kept_ack_has_room: assert property (@(posedge clk_i) disable iff (!rstn_i)
        kept_ack |-> !ff_full);

endmodule

`default_nettype wire

//--- source/trap_csr_regs.sv
/* mtvec and mepc with write-any-read-legal behavior, both zero after reset.
   writes land at the next edge, csr_rdata_o is a combinational read */
`timescale 1ns/1ps
`default_nettype none

module trap_csr_regs
(
    input  wire logic                clk_i,
    input  wire logic                rstn_i,

    // write strobe from the core
    input  wire logic                csr_we_i,
    input  wire fetch_pkg::csr_sel_t csr_sel_i,
    input  wire fetch_pkg::word_t    csr_wdata_i,
    output fetch_pkg::word_t         csr_rdata_o,

    // values used for redirect targets
    output fetch_pkg::mtvec_u        mtvec_o,
    output fetch_pkg::word_t         mepc_o
);

    import fetch_pkg::*;

    mtvec_u mtvec_q;
    word_t  mepc_q;

    // incoming word seen through the mtvec field layout
    mtvec_u mtvec_wr;
    mtvec_u mtvec_legal;

    assign mtvec_wr.raw = csr_wdata_i;

    // reserved modes fall back to direct, base is kept as written
    always_comb
    begin
        mtvec_legal = mtvec_wr;
        if (mtvec_wr.fields.mode != MTVEC_DIRECT && mtvec_wr.fields.mode != MTVEC_VECTORED)
            mtvec_legal.fields.mode = MTVEC_DIRECT;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            mtvec_q <= '0;
            mepc_q  <= '0;
        end
        else if (csr_we_i)
        begin
            if (csr_sel_i == CSR_MTVEC)
                mtvec_q <= mtvec_legal;
            else
                // instructions are word aligned, low bits are hardwired to zero
                mepc_q <= {csr_wdata_i[XLEN-1:2], 2'b00};
        end
    end

    assign csr_rdata_o = (csr_sel_i == CSR_MTVEC) ? mtvec_q.raw : mepc_q;

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

    // trap target logic in the fetch unit relies on a legal stored mode
    a_mtvec_mode_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mtvec_q.fields.mode inside {MTVEC_DIRECT, MTVEC_VECTORED});

endmodule

`default_nettype wire

//--- source/sync_fifo.sv
/* synchronous FIFO of 2**FF_SIZE_POT entries, data_o shows the head word while not empty.
   clear_i drops all entries at the next edge and wins over a write in the same cycle */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
#(
    parameter int unsigned BW          = 32,
    parameter int unsigned FF_SIZE_POT = 3
)
(
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic                 clear_i,

    // write port
    input  wire logic                 wr_i,
    input  wire logic [BW-1:0]        data_i,

    // read port
    input  wire logic                 rd_i,
    output logic      [BW-1:0]        data_o,

    // status
    output logic                      full_o,
    output logic                      empty_o,
    output logic      [FF_SIZE_POT:0] fill_count_o
);

    // storage, no reset needed since empty_o hides stale entries
    logic [BW-1:0] mem [2**FF_SIZE_POT];

    // pointers carry one extra wrap bit to tell full from empty
    logic [FF_SIZE_POT:0] wr_ptr_q;
    logic [FF_SIZE_POT:0] rd_ptr_q;

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i || clear_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (wr_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_i)
            mem[wr_ptr_q[FF_SIZE_POT-1:0]] <= data_i;
    end

    assign data_o = mem[rd_ptr_q[FF_SIZE_POT-1:0]];

    // same slot, different wrap bit means the buffer is full
    assign full_o  = (wr_ptr_q[FF_SIZE_POT] != rd_ptr_q[FF_SIZE_POT]) &&
                     (wr_ptr_q[FF_SIZE_POT-1:0] == rd_ptr_q[FF_SIZE_POT-1:0]);
    assign empty_o = (wr_ptr_q == rd_ptr_q);

    // modulo difference is exact thanks to the wrap bit
    assign fill_count_o = wr_ptr_q - rd_ptr_q;

    // the owner must throttle writes, a write into a full buffer would lose the head word
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_i && !clear_i |-> !full_o);

    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rd_i && !clear_i |-> !empty_o);

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
/* shared widths, boot address and CSR layouts of the RV32 fetch front end.
   only the mtvec mode values 0 and 1 are legal, other encodings are reserved */
`default_nettype none

package fetch_pkg;

    // data and address width
    localparam int unsigned XLEN = 32;

    // one instruction, program counter or CSR value
    typedef logic [XLEN-1:0] word_t;

    // first fetch address after reset
    localparam word_t BOOT_PC = 32'h8000_0000;

    // instruction buffer holds 2**BUF_DEPTH_POT words
    localparam int unsigned BUF_DEPTH_POT = 3;

    // trap cause code as delivered by the controller
    localparam int unsigned TRAP_CODE_W = 5;

    // source of the new pc on a redirect
    typedef enum logic [1:0] {
        PC_JUMP = 2'd0,
        PC_MEPC = 2'd1,
        PC_TRAP = 2'd2
    } pc_sel_t;

    // trap CSR addressed by a write or a read
    typedef enum logic {
        CSR_MTVEC = 1'b0,
        CSR_MEPC  = 1'b1
    } csr_sel_t;

    // encodings 2 and 3 are reserved
    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_t;

    typedef struct packed {
        logic [XLEN-3:0] base;
        mtvec_mode_t     mode;
    } mtvec_fields_t;

    // written by the core as a raw word, read by the fetch unit as base and mode
    typedef union packed {
        word_t         raw;
        mtvec_fields_t fields;
    } mtvec_u;

endpackage

`default_nettype wire
